// File: logic/fm_phase_pkg.sv
// phase datapath constants and detune tables
// tables follow the OPN/OPM detune scheme, values in phase increment lsbs
`default_nettype none

package fm_phase_pkg;

	localparam int PHASE_W     = 20; // accumulator, wraps mod 2^20
	localparam int PHASE_OUT_W = 10; // top bits sent to the waveform stage
	localparam int PIPE_DEPTH  = 7;  // clk_en steps from config read to phase out

	// detune base value from the low keycode bits
	function automatic logic [4:0] dt1_pow2(input logic [2:0] kf);
		case (kf)
			3'd0:    dt1_pow2 = 5'd16;
			3'd1:    dt1_pow2 = 5'd17;
			3'd2:    dt1_pow2 = 5'd19;
			3'd3:    dt1_pow2 = 5'd20;
			3'd4:    dt1_pow2 = 5'd22;
			3'd5:    dt1_pow2 = 5'd24;
			3'd6:    dt1_pow2 = 5'd26;
			default: dt1_pow2 = 5'd29;
		endcase
	endfunction

	// ceiling of the detune offset per amount
	function automatic logic [4:0] dt1_limit(input logic [1:0] amt);
		case (amt)
			2'd2:    dt1_limit = 5'd16;
			2'd3:    dt1_limit = 5'd22;
			default: dt1_limit = 5'd8; // amounts 0 and 1
		endcase
	endfunction

endpackage

`default_nettype wire

// File: logic/fm_phase_top.sv
// phase generator subsystem, register writes are plain single-cycle strobes
// sync marks the phase output of slot 0
`timescale 1ns/1ps
`default_nettype none

module fm_phase_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 clk_en,
	input  logic                                 wr,
	input  fm_slot_pkg::slot_idx_t               wr_slot,
	input  fm_slot_pkg::reg_field_e              wr_field,
	input  logic [fm_slot_pkg::WR_DATA_W-1:0]    wr_data,
	input  logic [6:0]                           lfo_mod,
	input  logic                                 pg_stop,
	output logic [fm_phase_pkg::PHASE_OUT_W-1:0] phase,
	output logic [4:0]                           keycode,
	output logic                                 sync
);

	fm_slot_pkg::slot_idx_t slot;
	logic                   zero;
	fm_slot_pkg::slot_cfg_t cfg;
	logic signed [7:0]      pm;

	slot_timer u_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.clk_en (clk_en),
		.slot   (slot),
		.zero   (zero)
	);

	slot_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.clk_en   (clk_en),
		.slot     (slot),
		.wr       (wr),
		.wr_slot  (wr_slot),
		.wr_field (wr_field),
		.wr_data  (wr_data),
		.cfg      (cfg)
	);

	pm_offset u_pm (
		.fnum    (cfg.fnum),
		.pms     (cfg.pms),
		.lfo_mod (lfo_mod),
		.pm      (pm)
	);

	phase_gen u_pg (
		.clk     (clk),
		.rst_n   (rst_n),
		.clk_en  (clk_en),
		.cfg     (cfg),
		.pm      (pm),
		.pg_stop (pg_stop),
		.keycode (keycode),
		.phase   (phase)
	);

	// frame marker lined up with the phase output
	slot_delay #(.width(1), .stages(fm_phase_pkg::PIPE_DEPTH)) u_sync_delay (
		.clk    (clk),
		.rst_n  (rst_n),
		.clk_en (clk_en),
		.din    (zero),
		.dout   (sync)
	);

endmodule

`default_nettype wire

// File: logic/fm_slot_pkg.sv
// slot configuration types for the 24-slot operator engine
// slot order is 6 channels x 4 operators, fixed by the phase loop timing
`default_nettype none

package fm_slot_pkg;

	localparam int NUM_SLOTS = 24;     // time-shared slots per frame

	localparam int FNUM_W    = 11;
	localparam int BLOCK_W   = 3;
	localparam int MUL_W     = 4;
	localparam int DT1_W     = 3;      // bit 2 sign, bits 1:0 amount
	localparam int PMS_W     = 3;
	localparam int WR_DATA_W = FNUM_W; // widest field sets the write bus

	typedef logic [4:0] slot_idx_t;

	// register write field selector
	typedef enum logic [2:0] {
		FLD_FNUM  = 3'd0,
		FLD_BLOCK = 3'd1,
		FLD_MUL   = 3'd2,
		FLD_DT1   = 3'd3,
		FLD_PMS   = 3'd4,
		FLD_PGRST = 3'd5  // one-shot phase reset request
	} reg_field_e;

	typedef struct packed {
		logic [FNUM_W-1:0]  fnum;
		logic [BLOCK_W-1:0] block;
		logic [MUL_W-1:0]   mul;
		logic [DT1_W-1:0]   dt1;
		logic [PMS_W-1:0]   pms;
		logic               pg_rst; // pending request while stored
	} slot_cfg_t;

endpackage

`default_nettype wire

// File: logic/phase_gen.sv
// phase increment pipeline and per-slot accumulator
// keycode follows a cfg read by 2 steps and the phase by 7
// the increment wraps at 20 bits for large mul values
`timescale 1ns/1ps
`default_nettype none

module phase_gen (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 clk_en,
	input  fm_slot_pkg::slot_cfg_t               cfg,
	input  logic signed [7:0]                    pm,
	input  logic                                 pg_stop,
	output logic [4:0]                           keycode,
	output logic [fm_phase_pkg::PHASE_OUT_W-1:0] phase
);

	localparam int PW = fm_phase_pkg::PHASE_W;

	logic [4:0]  keycode_ii;
	logic [2:0]  block_ii;
	logic [12:0] fnum_ii;    // doubled fnum plus pm stays positive
	logic [2:0]  dt1_ii, dt1_iii, dt1_iv;
	logic [3:0]  mul_ii, mul_iii, mul_iv, mul_v;
	logic        pg_rst_ii, pg_rst_iii, pg_rst_vi;

	logic [17:0] shifted_ii;
	logic [5:0]  kf_ii;
	logic [5:0]  dt1_kf_iii;
	logic [17:0] phinc_iii, phinc_iv;

	logic [4:0]  pow2_iii, limit_iii;
	logic [5:0]  unlimited_iii;
	logic [4:0]  dt1_offset_iv;
	logic [PW-1:0] phinc_v, phinc_vi;

	logic [PW-1:0] phase_old, phase_in;
	logic [fm_phase_pkg::PHASE_OUT_W-1:0] phase_vii;

	//////////////////////////////////////////////////
	// I  keycode and pm

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keycode_ii <= '0;
			block_ii   <= '0;
			fnum_ii    <= '0;
			dt1_ii     <= '0;
			mul_ii     <= '0;
			pg_rst_ii  <= 1'b0;
		end else if (clk_en) begin
			keycode_ii <= {cfg.block, cfg.fnum[10],
				cfg.fnum[10] ? (|cfg.fnum[9:7]) : (&cfg.fnum[9:7])};
			block_ii   <= cfg.block;
			fnum_ii    <= {1'b0, cfg.fnum, 1'b0} + {{5{pm[7]}}, pm};
			dt1_ii     <= cfg.dt1;
			mul_ii     <= cfg.mul;
			pg_rst_ii  <= cfg.pg_rst;
		end
	end

	//////////////////////////////////////////////////
	// II  octave shift, detune keycode

	always_comb begin
		if (block_ii < 3'd3)
			shifted_ii = {5'd0, fnum_ii} >> (3'd2 - block_ii);
		else
			shifted_ii = {5'd0, fnum_ii} << (block_ii - 3'd2); // 1..5

		case (dt1_ii[1:0])
			2'd1:    kf_ii = {1'b0, keycode_ii} - 6'd4; // wraps high below 4
			2'd2:    kf_ii = {1'b0, keycode_ii} + 6'd4;
			2'd3:    kf_ii = {1'b0, keycode_ii} + 6'd8;
			default: kf_ii = {1'b0, keycode_ii};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keycode    <= '0;
			phinc_iii  <= '0;
			dt1_kf_iii <= '0;
			dt1_iii    <= '0;
			mul_iii    <= '0;
			pg_rst_iii <= 1'b0;
		end else if (clk_en) begin
			keycode    <= keycode_ii;
			phinc_iii  <= shifted_ii;
			dt1_kf_iii <= kf_ii;
			dt1_iii    <= dt1_ii;
			mul_iii    <= mul_ii;
			pg_rst_iii <= pg_rst_ii;
		end
	end

	//////////////////////////////////////////////////
	// III  detune offset

	always_comb begin
		pow2_iii  = fm_phase_pkg::dt1_pow2(dt1_kf_iii[2:0]);
		limit_iii = fm_phase_pkg::dt1_limit(dt1_iii[1:0]);
		case (dt1_kf_iii[5:3])
			3'd5:    unlimited_iii = {pow2_iii, 1'b0};
			3'd6,
			3'd7:    unlimited_iii = 6'd0; // wrapped keycodes
			default: unlimited_iii = {1'b0, pow2_iii} >> (3'd4 - dt1_kf_iii[5:3]);
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phinc_iv      <= '0;
			dt1_offset_iv <= '0;
			dt1_iv        <= '0;
			mul_iv        <= '0;
		end else if (clk_en) begin
			phinc_iv      <= phinc_iii;
			dt1_offset_iv <= (unlimited_iii > {1'b0, limit_iii}) ?
				limit_iii : unlimited_iii[4:0];
			dt1_iv        <= dt1_iii;
			mul_iv        <= mul_iii;
		end
	end

	//////////////////////////////////////////////////
	// IV, V  apply detune, then multiplier

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phinc_v  <= '0;
			mul_v    <= '0;
			phinc_vi <= '0;
		end else if (clk_en) begin
			if (dt1_iv[1:0] == 2'd0)
				phinc_v <= {2'd0, phinc_iv};
			else if (dt1_iv[2])
				phinc_v <= {2'd0, phinc_iv} - {15'd0, dt1_offset_iv};
			else
				phinc_v <= {2'd0, phinc_iv} + {15'd0, dt1_offset_iv};
			mul_v <= mul_iv;

			if (mul_v == 4'd0)
				phinc_vi <= phinc_v >> 1; // x0.5
			else
				phinc_vi <= phinc_v * mul_v;
		end
	end

	//////////////////////////////////////////////////
	// VI, VII  accumulate and output

	always_comb begin
		if (pg_rst_vi)
			phase_in = '0;
		else if (pg_stop)
			phase_in = phase_old;
		else
			phase_in = phase_old + phinc_vi;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_vii <= '0;
			phase     <= '0;
		end else if (clk_en) begin
			phase_vii <= phase_in[PW-1 -: fm_phase_pkg::PHASE_OUT_W];
			phase     <= phase_vii;
		end
	end

	// one frame around so each slot meets its own phase again
	slot_delay #(.width(PW), .stages(fm_slot_pkg::NUM_SLOTS)) u_phase_loop (
		.clk    (clk),
		.rst_n  (rst_n),
		.clk_en (clk_en),
		.din    (phase_in),
		.dout   (phase_old)
	);

	// stage III to VI
	slot_delay #(.width(1), .stages(3)) u_rst_delay (
		.clk    (clk),
		.rst_n  (rst_n),
		.clk_en (clk_en),
		.din    (pg_rst_iii),
		.dout   (pg_rst_vi)
	);

endmodule

`default_nettype wire

// File: logic/pm_offset.sv
// LFO vibrato offset, combinational
// lfo_mod[6] sign, [5] fold, [4:2] position; bits 1:0 are finer than the table
`timescale 1ns/1ps
`default_nettype none

module pm_offset (
	input  logic [10:0]       fnum,
	input  logic [2:0]        pms,
	input  logic [6:0]        lfo_mod,
	output logic signed [7:0] pm
);

	logic [2:0] pos;     // folded lfo position 0..7
	logic [9:0] prod;
	logic [9:0] shifted;
	logic [6:0] mag;

	always_comb begin
		pos = lfo_mod[5] ? ~lfo_mod[4:2] : lfo_mod[4:2];
		prod = fnum[10:4] * pos; // at most 127 x 7

		// deeper pms shifts less
		if (pms == 3'd0)
			shifted = 10'd0;
		else
			shifted = prod >> (4'd8 - {1'b0, pms});

		mag = (shifted > 10'd127) ? 7'd127 : shifted[6:0]; // saturate
	end

	assign pm = lfo_mod[6] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

endmodule

`default_nettype wire

// File: logic/slot_delay.sv
// clk_en shift register, cleared on reset
// stages must be 2 or more
`timescale 1ns/1ps
`default_nettype none

module slot_delay #(
	parameter int width  = 1,
	parameter int stages = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             clk_en,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [stages-1:0][width-1:0] sh;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh <= '0;
		end else if (clk_en) begin
			sh <= {sh[stages-2:0], din}; // entry 0 newest
		end
	end

	assign dout = sh[stages-1];

endmodule

`default_nettype wire

// File: logic/slot_regs.sv
// per-slot settings, written any clk, read by the current slot
// writes to slots 24..31 are dropped
// the stored pg_rst bit is the pending phase reset request
`timescale 1ns/1ps
`default_nettype none

module slot_regs (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  clk_en,
	input  fm_slot_pkg::slot_idx_t                slot,
	input  logic                                  wr,
	input  fm_slot_pkg::slot_idx_t                wr_slot,
	input  fm_slot_pkg::reg_field_e               wr_field,
	input  logic [fm_slot_pkg::WR_DATA_W-1:0]     wr_data,
	output fm_slot_pkg::slot_cfg_t                cfg
);

	fm_slot_pkg::slot_cfg_t entry [fm_slot_pkg::NUM_SLOTS];
	logic                   wr_ok;

	assign wr_ok = wr && (wr_slot < fm_slot_pkg::NUM_SLOTS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < fm_slot_pkg::NUM_SLOTS; i++)
				entry[i] <= '0;
		end else begin
			// request handed out with this read
			if (clk_en)
				entry[slot].pg_rst <= 1'b0;
			// write comes second so a same-cycle request survives the clear
			if (wr_ok) begin
				case (wr_field)
					fm_slot_pkg::FLD_FNUM:
						entry[wr_slot].fnum <= wr_data[fm_slot_pkg::FNUM_W-1:0];
					fm_slot_pkg::FLD_BLOCK:
						entry[wr_slot].block <= wr_data[fm_slot_pkg::BLOCK_W-1:0];
					fm_slot_pkg::FLD_MUL:
						entry[wr_slot].mul <= wr_data[fm_slot_pkg::MUL_W-1:0];
					fm_slot_pkg::FLD_DT1:
						entry[wr_slot].dt1 <= wr_data[fm_slot_pkg::DT1_W-1:0];
					fm_slot_pkg::FLD_PMS:
						entry[wr_slot].pms <= wr_data[fm_slot_pkg::PMS_W-1:0];
					fm_slot_pkg::FLD_PGRST:
						entry[wr_slot].pg_rst <= 1'b1; // data ignored
					default: ; // unused opcodes
				endcase
			end
		end
	end

	// current slot straight out, pending flag included
	assign cfg = entry[slot];

endmodule

`default_nettype wire

// File: logic/slot_timer.sv
// slot counter, one step per clk_en, restarts at slot 0 on reset
`timescale 1ns/1ps
`default_nettype none

module slot_timer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clk_en,
	output fm_slot_pkg::slot_idx_t slot,
	output logic                   zero
);

	fm_slot_pkg::slot_idx_t cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (clk_en) begin
			if (cnt == fm_slot_pkg::slot_idx_t'(fm_slot_pkg::NUM_SLOTS - 1))
				cnt <= '0; // end of frame
			else
				cnt <= cnt + 1'b1;
		end
	end

	assign slot = cnt;
	assign zero = (cnt == '0); // frame start marker

endmodule

`default_nettype wire

// File: project.f
logic/fm_slot_pkg.sv
logic/fm_phase_pkg.sv
logic/slot_delay.sv
logic/slot_timer.sv
logic/slot_regs.sv
logic/pm_offset.sv
logic/phase_gen.sv
logic/fm_phase_top.sv
tests/fm_phase_props.sv
tests/fm_phase_tb.sv

// File: tests/fm_phase_props.sv
// concurrent checks bound into the slot timer and the phase pipeline
// ports a target does not have are tied to zero at its bind
`timescale 1ns/1ps
`default_nettype none

module fm_phase_props (
	input logic       clk,
	input logic       rst_n,
	input logic       clk_en,
	input logic [4:0] slot,
	input logic [9:0] phase,
	input logic [4:0] keycode
);

	int fails = 0;

	a_slot_range: assert property (@(posedge clk) disable iff (!rst_n) slot < 5'd24)
		else begin
			$error("slot index outside the 24-slot frame");
			fails++;
		end

	// nothing moves on a step without clk_en
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!clk_en |=> $stable(phase) && $stable(keycode) && $stable(slot))
		else begin
			$error("output changed while clk_en was low");
			fails++;
		end

	a_reset_zero: assert property (@(posedge clk)
		!rst_n |-> (slot == '0) && (phase == '0) && (keycode == '0))
		else begin
			$error("output not cleared during reset");
			fails++;
		end

endmodule

bind slot_timer fm_phase_props u_props (
	.clk     (clk),
	.rst_n   (rst_n),
	.clk_en  (clk_en),
	.slot    (slot),
	.phase   (10'd0),
	.keycode (5'd0)
);

bind phase_gen fm_phase_props u_props (
	.clk     (clk),
	.rst_n   (rst_n),
	.clk_en  (clk_en),
	.slot    (5'd0),
	.phase   (phase),
	.keycode (keycode)
);

`default_nettype wire

// File: tests/fm_phase_tb.sv
// random stimulus on the phase generator against a step-by-step slot model
// the model samples on the falling edge and inputs change 1 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module fm_phase_tb;

	localparam int STEPS_PER_TEST = 480; // 20 frames
	localparam int NUM_TESTS      = 6;
	localparam int TOTAL_STEPS    = STEPS_PER_TEST * NUM_TESTS;
	localparam int TIMEOUT_NS     = (TOTAL_STEPS + 4) * 20 * 2;

	typedef struct packed {
		logic        vld;
		logic [4:0]  slot;
		logic [4:0]  kc;
		logic        rst;
		logic [19:0] inc;
	} rd_entry_t;

	logic                    clk      = 1'b0;
	logic                    rst_n    = 1'b1;
	logic                    clk_en   = 1'b0;
	logic                    wr       = 1'b0;
	fm_slot_pkg::slot_idx_t  wr_slot  = '0;
	fm_slot_pkg::reg_field_e wr_field = fm_slot_pkg::FLD_FNUM;
	logic [10:0]             wr_data  = '0;
	logic [6:0]              lfo_mod  = '0;
	logic                    pg_stop  = 1'b0;
	logic [9:0]              phase;
	logic [4:0]              keycode;
	logic                    sync;

	integer seed   = 32'h4bd9d8dd;
	int     checks = 0;
	int     errors = 0;

	// model state
	fm_slot_pkg::slot_cfg_t m_cfg [fm_slot_pkg::NUM_SLOTS]; // pg_rst is the pending flag
	logic [19:0]            m_acc [fm_slot_pkg::NUM_SLOTS];
	rd_entry_t              hist [8];  // reads by step number mod 8
	int                     m_slot, m_step, last_sync;
	logic [9:0]             m_vii, exp_phase;
	logic [4:0]             exp_kc;
	logic                   exp_sync;

	fm_phase_top UUT (
		.clk (clk), .rst_n (rst_n), .clk_en (clk_en),
		.wr (wr), .wr_slot (wr_slot), .wr_field (wr_field), .wr_data (wr_data),
		.lfo_mod (lfo_mod), .pg_stop (pg_stop),
		.phase (phase), .keycode (keycode), .sync (sync)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// reference rules

	function automatic logic [4:0] kc_of(input fm_slot_pkg::slot_cfg_t c);
		logic low_bit;
		// top fnum bit picks between any and all of the next three
		if (c.fnum[10])
			low_bit = (c.fnum[9:7] != 3'b000);
		else
			low_bit = (c.fnum[9:7] == 3'b111);
		return {c.block, c.fnum[10], low_bit};
	endfunction

	function automatic int pm_of(input fm_slot_pkg::slot_cfg_t c, input logic [6:0] lfo);
		int pos;
		int mag;
		pos = lfo[5] ? 7 - lfo[4:2] : lfo[4:2]; // folded triangle
		mag = (c.pms == 0) ? 0 : (c.fnum[10:4] * pos) >> (8 - c.pms);
		if (mag > 127)
			mag = 127;
		return lfo[6] ? -mag : mag;
	endfunction

	function automatic logic [19:0] inc_of(input fm_slot_pkg::slot_cfg_t c,
		input logic [6:0] lfo);
		int          f, sh, kf, off;
		logic [19:0] inc;
		f  = 2 * c.fnum + pm_of(c, lfo);
		sh = (c.block < 3) ? f >> (2 - c.block) : f << (c.block - 2);
		case (c.dt1[1:0])
			2'd1:    kf = kc_of(c) - 4;
			2'd2:    kf = kc_of(c) + 4;
			2'd3:    kf = kc_of(c) + 8;
			default: kf = kc_of(c);
		endcase
		off = fm_phase_pkg::dt1_pow2(kf[2:0]);
		if (kf < 0 || (kf >> 3) > 5)
			off = 0; // below the table
		else if ((kf >> 3) == 5)
			off = off << 1;
		else
			off = off >> (4 - (kf >> 3));
		if (off > fm_phase_pkg::dt1_limit(c.dt1[1:0]))
			off = fm_phase_pkg::dt1_limit(c.dt1[1:0]);
		inc = sh;
		if (c.dt1[1:0] != 2'd0)
			inc = c.dt1[2] ? inc - off : inc + off;
		inc = (c.mul == 0) ? inc >> 1 : inc * c.mul; // wraps at 20 bits
		return inc;
	endfunction

	//////////////////////////////////////////////////
	// model steps on each falling edge with clk_en high

	always @(negedge clk) begin : model
		rd_entry_t e;
		rd_entry_t rd;
		if (!rst_n) begin
			for (int i = 0; i < fm_slot_pkg::NUM_SLOTS; i++) begin
				m_cfg[i] = '0;
				m_acc[i] = '0;
			end
			for (int i = 0; i < 8; i++)
				hist[i] = '0;
			m_slot = 0;
			m_step = 0;
			last_sync = -1;
			m_vii = '0;
			exp_phase = '0;
			exp_kc = '0;
			exp_sync = 1'b0;
		end else begin
			if (clk_en) begin
				check_value("phase", exp_phase, phase);
				check_value("keycode", exp_kc, keycode);
				check_value("sync", exp_sync, sync);
				if (sync) begin
					if (last_sync >= 0)
						check_value("sync_period", 24, m_step - last_sync);
					last_sync = m_step;
				end
				exp_phase = m_vii;
				exp_kc = hist[(m_step + 7) % 8].kc; // read one step back
				e = hist[(m_step + 3) % 8];          // read five steps back
				if (e.vld) begin
					if (e.rst)
						m_acc[e.slot] = '0;
					else if (!pg_stop)
						m_acc[e.slot] = m_acc[e.slot] + e.inc;
					m_vii = m_acc[e.slot][19:10];
				end else begin
					m_vii = '0;
				end
				exp_sync = hist[(m_step + 2) % 8].vld && (hist[(m_step + 2) % 8].slot == 0);
				rd.vld  = 1'b1;
				rd.slot = 5'(m_slot);
				rd.kc   = kc_of(m_cfg[m_slot]);
				rd.rst  = m_cfg[m_slot].pg_rst;
				rd.inc  = inc_of(m_cfg[m_slot], lfo_mod);
				m_cfg[m_slot].pg_rst = 1'b0;
				hist[m_step % 8] = rd;
				m_slot = (m_slot == fm_slot_pkg::NUM_SLOTS - 1) ? 0 : m_slot + 1;
				m_step++;
			end
			if (wr && wr_slot < fm_slot_pkg::NUM_SLOTS) begin
				case (wr_field)
					fm_slot_pkg::FLD_FNUM:  m_cfg[wr_slot].fnum = wr_data;
					fm_slot_pkg::FLD_BLOCK: m_cfg[wr_slot].block = wr_data[2:0];
					fm_slot_pkg::FLD_MUL:   m_cfg[wr_slot].mul = wr_data[3:0];
					fm_slot_pkg::FLD_DT1:   m_cfg[wr_slot].dt1 = wr_data[2:0];
					fm_slot_pkg::FLD_PMS:   m_cfg[wr_slot].pms = wr_data[2:0];
					fm_slot_pkg::FLD_PGRST: m_cfg[wr_slot].pg_rst = 1'b1;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	task automatic put_write(input fm_slot_pkg::reg_field_e fld);
		wr       = 1'b1;
		wr_slot  = 5'($random(seed)); // 24..31 dropped by the DUT
		wr_field = fld;
		wr_data  = 11'($random(seed));
	endtask

	task automatic drive_inputs(input int mode, input int done);
		logic [31:0]             r;
		fm_slot_pkg::reg_field_e extra;
		r = $random(seed);
		wr = 1'b0;
		case (mode)
			1:       extra = fm_slot_pkg::reg_field_e'({2'b11, r[4]}); // unused opcodes
			2:       extra = fm_slot_pkg::FLD_MUL;
			3:       extra = fm_slot_pkg::FLD_DT1;
			default: extra = fm_slot_pkg::FLD_PMS;
		endcase
		if (mode == 4) begin
			pg_stop = (done >= STEPS_PER_TEST / 3) && (done < 2 * STEPS_PER_TEST / 3);
			if (r[4:0] == 5'd0)
				put_write(fm_slot_pkg::FLD_PGRST);
		end else if (mode != 0 && r[1:0] == 2'd0) begin
			if (r[3:2] == 2'd0)
				put_write(fm_slot_pkg::FLD_FNUM);
			else if (r[3:2] == 2'd1)
				put_write(fm_slot_pkg::FLD_BLOCK);
			else
				put_write(extra);
		end
		if (mode == 5 && r[7:5] == 3'd0)
			lfo_mod = r[14:8];
	endtask

	task automatic run_test(input string name, input int mode);
		int done;
		int err_start;
		done = 0;
		err_start = errors;
		while (done < STEPS_PER_TEST) begin
			@(posedge clk);
			#1;
			clk_en = ($random(seed) & 3) != 0; // about 3 in 4
			if (clk_en)
				done++;
			drive_inputs(mode, done);
		end
		@(negedge clk); // model takes the last step
		#1;
		$display("test %-12s %0d steps, %0d errors", name, done, errors - err_start);
	endtask

	initial begin : main
		#1;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		run_test("reset", 0);
		run_test("keycode", 1);
		run_test("accumulate", 2);
		run_test("detune", 3);
		run_test("rst_stop", 4);
		run_test("vibrato", 5);
		errors += UUT.u_timer.u_props.fails + UUT.u_pg.u_props.fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the tests did not complete in the expected time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
